//--- verilog.f
source/noc_params.sv
source/circular_buffer.sv
source/input_buffer.sv
source/route_compute.sv
source/vc_allocator.sv
source/input_port.sv
source/router_input_stage.sv
verif/router_input_stage_checker.sv
verif/router_input_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, then decide on the log contents.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module router_input_stage_tb \
    -o router_input_stage_sim > sim.log 2>&1 &&
    ./obj_dir/router_input_stage_sim >> sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

//--- verif/router_input_stage_tb.sv
`timescale 1ns/1ps

module router_input_stage_tb;

    localparam int BUFFER_SIZE    = 8;
    localparam int PIPELINE_DEPTH = 5;
    localparam int VC_NUM         = noc_params::VC_NUM;
    localparam int PACKETS        = 400;
    localparam int RUN_LIMIT      = 60000; // cycles for traffic plus drain.
    localparam int REQUEST_LIMIT  = 300;   // cycles a loaded channel may lack a switch request.

    logic                           clk;
    logic                           rst;
    noc_params::flit_t              data_i;
    logic                           write_i;
    logic                           read_i;
    logic [noc_params::VC_SIZE-1:0] read_vc_i;
    noc_params::flit_t              data_o;
    noc_params::port_t              out_port_o;
    logic [VC_NUM-1:0]              on_off_o;
    logic [VC_NUM-1:0]              switch_request_o;
    logic [VC_NUM-1:0]              vc_allocatable_o;

    noc_params::flit_t              flit_q [VC_NUM][$];  // expected flits, oldest first.
    noc_params::port_t              route_q [VC_NUM][$]; // expected route of each flit.
    noc_params::port_t              cur_route [VC_NUM];  // route of the open packet.
    int                             flits_left [VC_NUM]; // flits still to send.
    int                             stall [VC_NUM];
    logic [noc_params::VC_SIZE-1:0] pkt_vc [VC_NUM];     // downstream channel per packet.
    logic [VC_NUM-1:0]              busy;                // packet open until its release.
    logic [VC_NUM-1:0]              pulse_due;
    logic [VC_NUM-1:0]              ds_used;             // downstream channels in flight.
    logic                           wr_pend, rd_pend;    // strobes driven last edge.
    noc_params::flit_t              wr_flit;
    noc_params::port_t              wr_route;
    logic [noc_params::VC_SIZE-1:0] rd_vc;
    int                             started;
    int                             cycles;

    router_input_stage #(
        .BUFFER_SIZE   (BUFFER_SIZE),
        .PIPELINE_DEPTH(PIPELINE_DEPTH),
        .X_CURRENT     (4'd3),
        .Y_CURRENT     (4'd3)
    ) i_router_input_stage (
        .clk             (clk),
        .rst             (rst),
        .data_i          (data_i),
        .write_i         (write_i),
        .read_i          (read_i),
        .read_vc_i       (read_vc_i),
        .data_o          (data_o),
        .out_port_o      (out_port_o),
        .on_off_o        (on_off_o),
        .switch_request_o(switch_request_o),
        .vc_allocatable_o(vc_allocatable_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // xy routing seen from router (3,3), columns first.
    function automatic noc_params::port_t expected_route(input noc_params::flit_t f);
        if (f.data.head.x_dest > 4'd3)
            return noc_params::EAST;
        if (f.data.head.x_dest < 4'd3)
            return noc_params::WEST;
        if (f.data.head.y_dest > 4'd3)
            return noc_params::SOUTH;
        if (f.data.head.y_dest < 4'd3)
            return noc_params::NORTH;
        return noc_params::LOCAL;
    endfunction

    function automatic logic drained();
        logic done;
        done = !wr_pend && !rd_pend && (busy == '0);
        for (int v = 0; v < VC_NUM; v++)
            done = done && (flit_q[v].size() == 0) && (flits_left[v] == 0);
        return done;
    endfunction

    task automatic check_reset_outputs();
        assert (switch_request_o == '0)
            else stop_run($sformatf("error switch_request_o: got 0x%h, expected 0x0",
                                    switch_request_o));
        assert (vc_allocatable_o == '1)
            else stop_run($sformatf("error vc_allocatable_o: got 0x%h, expected 0xf",
                                    vc_allocatable_o));
        assert (on_off_o == '1)
            else stop_run($sformatf("error on_off_o: got 0x%h, expected 0xf", on_off_o));
        assert (out_port_o == noc_params::LOCAL)
            else stop_run($sformatf("error out_port_o: got 0x%h, expected 0x0", out_port_o));
    endtask

    // outputs here still reflect the state before this edge.
    task automatic check_outputs();
        noc_params::flit_t exp_flit;
        logic              exp_on;
        for (int v = 0; v < VC_NUM; v++)
        begin
            exp_on = (BUFFER_SIZE - flit_q[v].size()) > PIPELINE_DEPTH;
            assert (on_off_o[v] == exp_on)
                else stop_run($sformatf("error on_off_o[%0d]: got 0x%h, expected 0x%h",
                                        v, on_off_o[v], exp_on));
            if (pulse_due[v])
            begin
                assert (vc_allocatable_o[v])
                    else stop_run($sformatf("error vc_allocatable_o[%0d]: got 0x0, expected 0x1",
                                            v));
                pulse_due[v] = 1'b0;
                busy[v]      = 1'b0; // channel may take a new packet.
            end
            if (flit_q[v].size() != 0 && !switch_request_o[v])
                stall[v]++;
            else
                stall[v] = 0;
            if (stall[v] > REQUEST_LIMIT)
                stop_run($sformatf("timeout: channel %0d never offered its flits to the switch",
                                   v));
        end
        if (rd_pend)
        begin
            exp_flit = flit_q[rd_vc][0];
            assert (data_o.flit_label == exp_flit.flit_label)
                else stop_run($sformatf("error data_o.flit_label: got 0x%h, expected 0x%h",
                                        data_o.flit_label, exp_flit.flit_label));
            assert (data_o.data.raw == exp_flit.data.raw)
                else stop_run($sformatf("error data_o.data: got 0x%h, expected 0x%h",
                                        data_o.data.raw, exp_flit.data.raw));
            assert (out_port_o == route_q[rd_vc][0])
                else stop_run($sformatf("error out_port_o: got 0x%h, expected 0x%h",
                                        out_port_o, route_q[rd_vc][0]));
            if (exp_flit.flit_label == noc_params::HEAD)
            begin
                assert (!ds_used[data_o.vc_id])
                    else stop_run("downstream channel given to two packets in flight");
                ds_used[data_o.vc_id] = 1'b1;
                pkt_vc[rd_vc]         = data_o.vc_id;
            end
            else
            begin
                assert (data_o.vc_id == pkt_vc[rd_vc])
                    else stop_run($sformatf("error data_o.vc_id: got 0x%h, expected 0x%h",
                                            data_o.vc_id, pkt_vc[rd_vc]));
            end
            if (exp_flit.flit_label == noc_params::TAIL)
            begin
                ds_used[pkt_vc[rd_vc]] = 1'b0;
                pulse_due[rd_vc]       = 1'b1; // release expected next cycle.
            end
        end
    endtask

    // strobes driven last edge land at this edge.
    task automatic commit_pending();
        if (wr_pend)
        begin
            flit_q[wr_flit.vc_id].push_back(wr_flit);
            route_q[wr_flit.vc_id].push_back(wr_route);
        end
        if (rd_pend)
        begin
            void'(flit_q[rd_vc].pop_front());
            void'(route_q[rd_vc].pop_front());
        end
    endtask

    task automatic drive_next();
        int                v;
        int                start;
        noc_params::flit_t f;
        wr_pend = 1'b0;
        rd_pend = 1'b0;
        start   = $urandom_range(VC_NUM - 1, 0);
        // switch side, one random ready channel or idle.
        if ($urandom_range(3, 0) != 0)
        begin
            for (int i = 0; i < VC_NUM; i++)
            begin
                v = (start + i) % VC_NUM;
                if (!rd_pend && switch_request_o[v] && flit_q[v].size() != 0)
                begin
                    rd_pend = 1'b1;
                    rd_vc   = v[noc_params::VC_SIZE-1:0];
                end
            end
        end
        v           = $urandom_range(VC_NUM - 1, 0);
        f.vc_id     = v[noc_params::VC_SIZE-1:0];
        f.data.raw  = 16'($urandom);
        f.flit_label = noc_params::BODY;
        if ($urandom_range(3, 0) != 0 && on_off_o[v])
        begin
            if (flits_left[v] > 0)
            begin
                f.flit_label = (flits_left[v] == 1) ? noc_params::TAIL : noc_params::BODY;
                flits_left[v]--;
                wr_pend = 1'b1;
            end
            else if (!busy[v] && started < PACKETS)
            begin
                f.flit_label       = noc_params::HEAD;
                f.data.head.x_dest = 4'($urandom_range(7, 0));
                f.data.head.y_dest = 4'($urandom_range(7, 0));
                cur_route[v]       = expected_route(f);
                flits_left[v]      = $urandom_range(5, 1); // 2 to 6 flits per packet.
                busy[v]            = 1'b1;
                started++;
                wr_pend = 1'b1;
            end
        end
        wr_flit  = f;
        wr_route = cur_route[v];
        write_i   <= wr_pend;
        data_i    <= f;
        read_i    <= rd_pend;
        read_vc_i <= rd_vc;
    endtask

    initial
    begin
        void'($urandom(32'h4ff7_2c34));
        rst       = 1'b1;
        data_i    = '0;
        write_i   = 1'b0;
        read_i    = 1'b0;
        read_vc_i = '0;
        busy      = '0;
        pulse_due = '0;
        ds_used   = '0;
        wr_pend   = 1'b0;
        rd_pend   = 1'b0;
        wr_flit   = '0;
        wr_route  = noc_params::LOCAL;
        rd_vc     = '0;
        started   = 0;
        cycles    = 0;
        for (int v = 0; v < VC_NUM; v++)
        begin
            flits_left[v] = 0;
            stall[v]      = 0;
            pkt_vc[v]     = '0;
            cur_route[v]  = noc_params::LOCAL;
        end
        repeat (4)
        begin
            @(posedge clk);
            check_reset_outputs();
        end
        rst <= 1'b0;
        @(posedge clk);
        check_reset_outputs(); // reset values hold until this edge.
        while (started < PACKETS || !drained())
        begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_LIMIT)
                stop_run("timeout: packets did not all drain within the cycle limit");
            check_outputs();
            commit_pending();
            drive_next();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verif/router_input_stage_checker.sv
`timescale 1ns/1ps

module router_input_stage_checker (
    input logic                           clk,
    input logic                           rst,
    input noc_params::flit_t              data_i,
    input logic                           write_i,
    input logic                           read_i,
    input logic [noc_params::VC_SIZE-1:0] read_vc_i,
    input noc_params::flit_t              data_o,
    input noc_params::port_t              out_port_o,
    input logic [noc_params::VC_NUM-1:0]  switch_request_o,
    input logic [noc_params::VC_NUM-1:0]  vc_allocatable_o
);

    logic [1:0]                    settle; // edges since reset, saturating.
    logic [noc_params::VC_NUM-1:0] begun;  // packet opened per channel.

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            settle <= '0;
            begun  <= '0;
        end
        else
        begin
            if (settle != 2'd3)
                settle <= settle + 2'd1;
            for (int v = 0; v < noc_params::VC_NUM; v++)
            begin
                if (write_i && data_i.flit_label == noc_params::HEAD && int'(data_i.vc_id) == v)
                    begun[v] <= 1'b1;
                else if (read_i && int'(read_vc_i) == v &&
                         data_o.flit_label == noc_params::TAIL)
                    begun[v] <= 1'b0; // tail gone, packet closed.
            end
        end
    end

    // release is a single cycle pulse once the reset value is gone.
    assert property (@(posedge clk) disable iff (rst || settle < 2'd2)
        (vc_allocatable_o & $past(vc_allocatable_o)) == '0)
        else $error("vc_allocatable_o stayed high for two cycles");

    assert property (@(posedge clk) disable iff (rst)
        (switch_request_o & ~begun) == '0)
        else $error("switch request raised on a channel with no packet begun");

    assert property (@(posedge clk) disable iff (rst)
        out_port_o inside {noc_params::LOCAL, noc_params::NORTH, noc_params::SOUTH,
                           noc_params::WEST, noc_params::EAST})
        else $error("out_port_o holds no legal port");

endmodule

bind router_input_stage router_input_stage_checker i_router_input_stage_checker (
    .clk             (clk),
    .rst             (rst),
    .data_i          (data_i),
    .write_i         (write_i),
    .read_i          (read_i),
    .read_vc_i       (read_vc_i),
    .data_o          (data_o),
    .out_port_o      (out_port_o),
    .switch_request_o(switch_request_o),
    .vc_allocatable_o(vc_allocatable_o)
);

//--- source/router_input_stage.sv
`timescale 1ns/1ps

module router_input_stage #(
    parameter int                                BUFFER_SIZE    = 8,
    parameter int                                PIPELINE_DEPTH = 5,
    parameter logic [noc_params::COORD_SIZE-1:0] X_CURRENT      = '0,
    parameter logic [noc_params::COORD_SIZE-1:0] Y_CURRENT      = '0
)(
    input  logic                           clk,
    input  logic                           rst,
    input  noc_params::flit_t              data_i,
    input  logic                           write_i,
    input  logic                           read_i,
    input  logic [noc_params::VC_SIZE-1:0] read_vc_i,
    output noc_params::flit_t              data_o,
    output noc_params::port_t              out_port_o,
    output logic [noc_params::VC_NUM-1:0]  on_off_o,
    output logic [noc_params::VC_NUM-1:0]  switch_request_o,
    output logic [noc_params::VC_NUM-1:0]  vc_allocatable_o
);

    noc_params::port_t              head_port;  // route of the incoming flit.
    logic [noc_params::VC_NUM-1:0]  vc_request;
    logic [noc_params::VC_NUM-1:0]  vc_valid;   // one-hot grant.
    logic [noc_params::VC_SIZE-1:0] vc_new;

    route_compute #(
        .X_CURRENT(X_CURRENT),
        .Y_CURRENT(Y_CURRENT)
    ) i_route_compute (
        .data_i    (data_i),
        .out_port_o(head_port)
    );

    input_port #(
        .BUFFER_SIZE   (BUFFER_SIZE),
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) i_input_port (
        .clk             (clk),
        .rst             (rst),
        .data_i          (data_i),
        .write_i         (write_i),
        .read_i          (read_i),
        .read_vc_i       (read_vc_i),
        .out_port_i      (head_port),
        .vc_valid_i      (vc_valid),
        .vc_new_i        (vc_new),
        .data_o          (data_o),
        .out_port_o      (out_port_o),
        .on_off_o        (on_off_o),
        .switch_request_o(switch_request_o),
        .vc_request_o    (vc_request),
        .vc_allocatable_o(vc_allocatable_o)
    );

    // the release pulse frees what each buffer held.
    vc_allocator i_vc_allocator (
        .clk         (clk),
        .rst         (rst),
        .vc_request_i(vc_request),
        .vc_release_i(vc_allocatable_o),
        .vc_valid_o  (vc_valid),
        .vc_new_o    (vc_new)
    );

endmodule

//--- source/input_port.sv
`timescale 1ns/1ps

module input_port #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic                           clk,
    input  logic                           rst,
    input  noc_params::flit_t              data_i,
    input  logic                           write_i,
    input  logic                           read_i,
    input  logic [noc_params::VC_SIZE-1:0] read_vc_i,
    input  noc_params::port_t              out_port_i,
    input  logic [noc_params::VC_NUM-1:0]  vc_valid_i,
    input  logic [noc_params::VC_SIZE-1:0] vc_new_i,
    output noc_params::flit_t              data_o,
    output noc_params::port_t              out_port_o,
    output logic [noc_params::VC_NUM-1:0]  on_off_o,
    output logic [noc_params::VC_NUM-1:0]  switch_request_o,
    output logic [noc_params::VC_NUM-1:0]  vc_request_o,
    output logic [noc_params::VC_NUM-1:0]  vc_allocatable_o
);

    noc_params::flit_t             vc_data [noc_params::VC_NUM]; // head of each ring.
    noc_params::port_t             vc_port [noc_params::VC_NUM]; // stored route per channel.
    logic [noc_params::VC_NUM-1:0] vc_write, vc_read;
    logic [noc_params::VC_NUM-1:0] vc_full, vc_empty;

    for (genvar i = 0; i < noc_params::VC_NUM; i++)
    begin : gen_vc
        // write goes to the channel named in the flit.
        assign vc_write[i] = write_i & (int'(data_i.vc_id) == i) & ~vc_full[i];
        assign vc_read[i]  = read_i & (int'(read_vc_i) == i) & ~vc_empty[i]; // switch pick.

        input_buffer #(
            .BUFFER_SIZE   (BUFFER_SIZE),
            .PIPELINE_DEPTH(PIPELINE_DEPTH)
        ) i_input_buffer (
            .clk             (clk),
            .rst             (rst),
            .data_i          (data_i),
            .read_i          (vc_read[i]),
            .write_i         (vc_write[i]),
            .vc_new_i        (vc_new_i),
            .vc_valid_i      (vc_valid_i[i]),
            .out_port_i      (out_port_i),
            .data_o          (vc_data[i]),
            .is_full_o       (vc_full[i]),
            .is_empty_o      (vc_empty[i]),
            .on_off_o        (on_off_o[i]),
            .out_port_o      (vc_port[i]),
            .vc_request_o    (vc_request_o[i]),
            .vc_allocatable_o(vc_allocatable_o[i]),
            .switch_request_o(switch_request_o[i])
        );
    end

    // selected channel onto the shared outputs.
    assign data_o     = vc_data[read_vc_i];
    assign out_port_o = vc_port[read_vc_i];

endmodule

//--- source/vc_allocator.sv
`timescale 1ns/1ps

module vc_allocator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [noc_params::VC_NUM-1:0]  vc_request_i,
    input  logic [noc_params::VC_NUM-1:0]  vc_release_i,
    output logic [noc_params::VC_NUM-1:0]  vc_valid_o,
    output logic [noc_params::VC_SIZE-1:0] vc_new_o
);

    logic [noc_params::VC_NUM-1:0]  vc_free;                     // downstream channels free.
    logic [noc_params::VC_SIZE-1:0] vc_owner [noc_params::VC_NUM]; // held channel per requester.
    logic [noc_params::VC_SIZE-1:0] rr_ptr, rr_next;             // first requester to look at.
    logic [noc_params::VC_SIZE-1:0] winner;
    logic                           winner_found, free_found, grant;

    // round robin pick among requesters.
    always_comb
    begin
        int idx;
        int next_idx;
        winner       = '0;
        rr_next      = rr_ptr;
        winner_found = 1'b0;
        for (int i = 0; i < noc_params::VC_NUM; i++)
        begin
            idx      = (int'(rr_ptr) + i) % noc_params::VC_NUM;
            next_idx = (idx + 1) % noc_params::VC_NUM; // requester after this one.
            if (!winner_found && vc_request_i[idx])
            begin
                winner       = idx[noc_params::VC_SIZE-1:0];
                rr_next      = next_idx[noc_params::VC_SIZE-1:0];
                winner_found = 1'b1;
            end
        end
    end

    // lowest numbered free downstream channel.
    always_comb
    begin
        int idx;
        vc_new_o   = '0;
        free_found = 1'b0;
        for (int i = noc_params::VC_NUM - 1; i >= 0; i--)
        begin
            idx = i;
            if (vc_free[i])
            begin
                vc_new_o   = idx[noc_params::VC_SIZE-1:0];
                free_found = 1'b1;
            end
        end
    end

    assign grant = winner_found & free_found;

    always_comb
    begin
        vc_valid_o = '0;
        if (grant)
            vc_valid_o[winner] = 1'b1; // one-hot grant pulse.
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            vc_free <= '1;
            rr_ptr  <= '0;
            for (int i = 0; i < noc_params::VC_NUM; i++)
                vc_owner[i] <= '0;
        end
        else
        begin
            // release first, a grant only takes an already free channel.
            for (int i = 0; i < noc_params::VC_NUM; i++)
                if (vc_release_i[i])
                    vc_free[vc_owner[i]] <= 1'b1;
            if (grant)
            begin
                vc_free[vc_new_o] <= 1'b0;
                vc_owner[winner]  <= vc_new_o;
                rr_ptr            <= rr_next; // skip past the winner.
            end
        end
    end

endmodule

//--- source/route_compute.sv
`timescale 1ns/1ps

module route_compute #(
    parameter logic [noc_params::COORD_SIZE-1:0] X_CURRENT = '0,
    parameter logic [noc_params::COORD_SIZE-1:0] Y_CURRENT = '0
)(
    input  noc_params::flit_t data_i,
    output noc_params::port_t out_port_o
);

    logic [noc_params::COORD_SIZE-1:0] dest_x;
    logic [noc_params::COORD_SIZE-1:0] dest_y;

    // payload read as a head destination.
    assign dest_x = data_i.data.head.x_dest;
    assign dest_y = data_i.data.head.y_dest;

    // xy routing, columns first.
    always_comb
    begin
        if (dest_x > X_CURRENT)
            out_port_o = noc_params::EAST;
        else if (dest_x < X_CURRENT)
            out_port_o = noc_params::WEST;
        else if (dest_y > Y_CURRENT)
            out_port_o = noc_params::SOUTH; // rows grow southwards.
        else if (dest_y < Y_CURRENT)
            out_port_o = noc_params::NORTH;
        else
            out_port_o = noc_params::LOCAL; // packet has arrived.
    end

endmodule

//--- source/input_buffer.sv
`timescale 1ns/1ps

module input_buffer #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic                           clk,
    input  logic                           rst,
    input  noc_params::flit_t              data_i,
    input  logic                           read_i,
    input  logic                           write_i,
    input  logic [noc_params::VC_SIZE-1:0] vc_new_i,
    input  logic                           vc_valid_i,
    input  noc_params::port_t              out_port_i,
    output noc_params::flit_t              data_o,
    output logic                           is_full_o,
    output logic                           is_empty_o,
    output logic                           on_off_o,
    output noc_params::port_t              out_port_o,
    output logic                           vc_request_o,
    output logic                           vc_allocatable_o,
    output logic                           switch_request_o
);

    typedef enum logic [1:0] {IDLE, VA, SA} state_t;

    state_t                         state, state_next;
    logic [noc_params::VC_SIZE-1:0] downstream_vc, downstream_vc_next;
    noc_params::port_t              out_port_next;
    logic                           end_packet, end_packet_next; // tail already stored.
    logic                           vc_allocatable_next;
    logic                           read_cmd, write_cmd;
    logic                           head_in, follow_in, tail_out;
    noc_params::flit_t              read_flit;

    circular_buffer #(
        .BUFFER_SIZE   (BUFFER_SIZE),
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) i_circular_buffer (
        .clk       (clk),
        .rst       (rst),
        .data_i    (data_i),
        .read_i    (read_cmd),
        .write_i   (write_cmd),
        .data_o    (read_flit),
        .is_full_o (is_full_o),
        .is_empty_o(is_empty_o),
        .on_off_o  (on_off_o)
    );

    assign head_in   = write_i & (data_i.flit_label == noc_params::HEAD);
    // body or tail of the packet still being received.
    assign follow_in = write_i & ~end_packet &
                       ((data_i.flit_label == noc_params::BODY) |
                        (data_i.flit_label == noc_params::TAIL));
    assign tail_out  = read_i & ~is_empty_o & (read_flit.flit_label == noc_params::TAIL);

    assign switch_request_o = (state == SA) & ~is_empty_o; // ready for the crossbar.

    // outgoing flit carries the downstream channel.
    always_comb
    begin
        data_o.flit_label = read_flit.flit_label;
        data_o.vc_id      = downstream_vc;
        data_o.data.raw   = read_flit.data.raw;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state            <= IDLE;
            out_port_o       <= noc_params::LOCAL;
            downstream_vc    <= '0;
            end_packet       <= 1'b0;
            vc_allocatable_o <= 1'b1; // channel free out of reset.
        end
        else
        begin
            state            <= state_next;
            out_port_o       <= out_port_next;
            downstream_vc    <= downstream_vc_next;
            end_packet       <= end_packet_next;
            vc_allocatable_o <= vc_allocatable_next;
        end
    end

    always_comb
    begin
        state_next          = state;
        out_port_next       = out_port_o;
        downstream_vc_next  = downstream_vc;
        end_packet_next     = end_packet;
        vc_allocatable_next = 1'b0;
        vc_request_o        = 1'b0;
        read_cmd            = 1'b0;
        write_cmd           = 1'b0;

        unique case (state)
            IDLE:
            begin
                // only a head into an empty ring opens a packet.
                if (head_in & is_empty_o)
                begin
                    state_next      = VA;
                    out_port_next   = out_port_i; // route of this packet.
                    end_packet_next = 1'b0;
                    write_cmd       = 1'b1;
                end
            end

            VA:
            begin
                vc_request_o = 1'b1; // ask for a downstream channel.
                if (vc_valid_i)
                begin
                    state_next         = SA;
                    downstream_vc_next = vc_new_i; // held until the tail leaves.
                end
                write_cmd = follow_in;
                if (follow_in & (data_i.flit_label == noc_params::TAIL))
                    end_packet_next = 1'b1;
            end

            SA:
            begin
                read_cmd  = read_i;
                write_cmd = follow_in;
                if (follow_in & (data_i.flit_label == noc_params::TAIL))
                    end_packet_next = 1'b1;
                if (tail_out)
                begin
                    state_next          = IDLE;
                    vc_allocatable_next = 1'b1; // one cycle release pulse.
                end
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

//--- source/circular_buffer.sv
`timescale 1ns/1ps

module circular_buffer #(
    parameter int BUFFER_SIZE    = 8,
    parameter int PIPELINE_DEPTH = 5
)(
    input  logic              clk,
    input  logic              rst,
    input  noc_params::flit_t data_i,
    input  logic              read_i,
    input  logic              write_i,
    output noc_params::flit_t data_o,
    output logic              is_full_o,
    output logic              is_empty_o,
    output logic              on_off_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(BUFFER_SIZE - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUFFER_SIZE);
    // largest fill that still leaves more than PIPELINE_DEPTH free slots.
    localparam logic [CNT_W-1:0] ON_MAX_CNT = CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH - 1);

    noc_params::flit_t mem [BUFFER_SIZE]; // flit storage.

    logic [PTR_W-1:0] rd_ptr; // oldest flit.
    logic [PTR_W-1:0] wr_ptr; // next free slot.
    logic [CNT_W-1:0] count;  // flits held.
    logic             do_read, do_write;

    assign is_full_o  = (count == FULL_CNT);
    assign is_empty_o = (count == '0);
    assign on_off_o   = (count <= ON_MAX_CNT); // upstream may keep sending.

    assign do_read  = read_i & ~is_empty_o;
    assign do_write = write_i & ~is_full_o; // writes to a full ring are lost.

    assign data_o = mem[rd_ptr]; // fall through, no read latency.

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1; // wrap at the end.
            if (do_read)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            // fill level moves only when one side acts alone.
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/noc_params.sv
package noc_params;

    // router port sizes.
    localparam int VC_NUM         = 4;  // virtual channels per port.
    localparam int VC_SIZE        = 2;  // bits of a channel id.
    localparam int COORD_SIZE     = 4;  // bits of one mesh coordinate.
    localparam int FLIT_DATA_SIZE = 16; // payload bits.

    // position of a flit within its packet.
    typedef enum logic [1:0] {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_label_t;

    // router output directions.
    typedef enum logic [2:0] {
        LOCAL,
        NORTH,
        SOUTH,
        WEST,
        EAST
    } port_t;

    // head payload seen as a destination.
    typedef struct packed {
        logic [COORD_SIZE-1:0]                  x_dest; // destination column.
        logic [COORD_SIZE-1:0]                  y_dest; // destination row.
        logic [FLIT_DATA_SIZE-2*COORD_SIZE-1:0] spare;  // unused by routing.
    } head_data_t;

    // same payload word, two readings.
    typedef union packed {
        logic [FLIT_DATA_SIZE-1:0] raw;  // plain data.
        head_data_t                head; // destination of a head flit.
    } flit_data_t;

    typedef struct packed {
        flit_label_t        flit_label;
        logic [VC_SIZE-1:0] vc_id; // channel on the link.
        flit_data_t         data;
    } flit_t;

endpackage
